// File: common/ex_pkg.sv
package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Datapath word
  localparam int unsigned data_w = 32;
  // Register index, integer and FP register files together
  localparam int unsigned reg_addr_w = 6;
  // Shift amount taken from operand B
  localparam int unsigned shamt_w = 5;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  typedef logic [data_w-1:0]     data_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////

  // ALU operators, branch compares at the top of the range
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, only MUL_MUL is single cycle
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

endpackage

// File: alu/ex_alu.sv
`timescale 1ns/100ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e operator_i,
  input  data_t   operand_a_i,
  input  data_t   operand_b_i,
  output data_t   result_o,
  output logic    comparison_result_o
);

  // Adder control
  logic            sub_en;
  logic            cmp_signed;
  logic [data_w:0] adder_op_a;
  logic [data_w:0] adder_op_b;
  logic [data_w:0] adder_sum;

  // Comparator outputs
  logic is_equal;
  logic is_less;
  logic cmp_bit;

  // Shifter
  logic [shamt_w-1:0] shamt;
  data_t              shift_left;
  data_t              shift_right;
  data_t              shift_arith;

  //////////////////////////////////////////////////
  // Shared adder and subtractor
  //////////////////////////////////////////////////

  // Everything except ADD runs through the subtractor
  assign sub_en = (operator_i != ALU_ADD);

  // Signed compares extend with the sign bit, unsigned with zero
  assign cmp_signed = (operator_i == ALU_SLT) || (operator_i == ALU_LT) ||
                      (operator_i == ALU_GE);

  assign adder_op_a = {cmp_signed & operand_a_i[data_w-1], operand_a_i};
  assign adder_op_b = {cmp_signed & operand_b_i[data_w-1], operand_b_i};

  // Two's complement subtract via inverted B and carry in
  assign adder_sum = adder_op_a + (sub_en ? ~adder_op_b : adder_op_b) +
                     {{data_w{1'b0}}, sub_en};

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign is_equal = (operand_a_i == operand_b_i);
  // 33-bit difference cannot overflow, so its top bit is the sign
  assign is_less  = adder_sum[data_w];

  always_comb begin
    case (operator_i)
      ALU_EQ:                    cmp_bit = is_equal;
      ALU_NE:                    cmp_bit = ~is_equal;
      ALU_LT, ALU_LTU:           cmp_bit = is_less;
      ALU_GE, ALU_GEU:           cmp_bit = ~is_less;
      ALU_SLT, ALU_SLTU:         cmp_bit = is_less;
      // Low for every non-compare operator
      default:                   cmp_bit = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp_bit;

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  assign shamt       = operand_b_i[shamt_w-1:0];
  assign shift_left  = operand_a_i << shamt;
  assign shift_right = operand_a_i >> shamt;
  assign shift_arith = data_t'($signed(operand_a_i) >>> shamt);

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_sum[data_w-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = shift_left;
      ALU_SRL:          result_o = shift_right;
      ALU_SRA:          result_o = shift_arith;
      // Compares return the flag zero-extended
      default:          result_o = {{(data_w-1){1'b0}}, comparison_result_o};
    endcase
  end

endmodule

// File: mult/ex_mult.sv
`timescale 1ns/100ps

module ex_mult
  import ex_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable_i,
  input  mul_op_e    operator_i,
  input  data_t      op_a_i,
  input  data_t      op_b_i,
  input  logic [1:0] signed_mode_i,
  input  logic       ex_ready_i,
  output data_t      result_o,
  output logic       multicycle_o,
  output logic       ready_o
);

  // Two-state sequencer for the high products
  typedef enum logic {
    MULT_IDLE,
    MULT_FINISH
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  logic mult_start;

  // Sign-extended operand A and the two halves of B
  logic signed [data_w:0]     op_a_ext;
  logic signed [data_w/2:0]   op_b_lo;
  logic signed [data_w/2:0]   op_b_hi;

  // Partial products, 33 x 17 bits each
  logic signed [49:0] pp_lo_d;
  logic signed [49:0] pp_hi_d;
  logic signed [49:0] pp_lo_q;
  logic signed [49:0] pp_hi_q;

  // Full product rebuilt in the second cycle
  logic signed [65:0] pp_lo_ext;
  logic signed [65:0] pp_hi_ext;
  logic signed [65:0] prod_full;

  data_t mul_lo;

  //////////////////////////////////////////////////
  // Partial products
  //////////////////////////////////////////////////

  // Bit 0 of the mode marks A as signed, bit 1 marks B
  assign op_a_ext = {signed_mode_i[0] & op_a_i[data_w-1], op_a_i};
  assign op_b_lo  = {1'b0, op_b_i[data_w/2-1:0]};
  assign op_b_hi  = {signed_mode_i[1] & op_b_i[data_w-1], op_b_i[data_w-1:data_w/2]};

  assign pp_lo_d = op_a_ext * op_b_lo;
  assign pp_hi_d = op_a_ext * op_b_hi;

  // Held across FINISH so the result stays put under back-pressure
  always_ff @(posedge clk) begin
    if (mult_start) begin
      pp_lo_q <= pp_lo_d;
      pp_hi_q <= pp_hi_d;
    end
  end

  assign pp_lo_ext = pp_lo_q;
  assign pp_hi_ext = pp_hi_q;
  assign prod_full = (pp_hi_ext <<< (data_w/2)) + pp_lo_ext;

  // Single-cycle low product
  assign mul_lo = op_a_i * op_b_i;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  assign mult_start = enable_i && (operator_i != MUL_MUL) && (state_q == MULT_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE:   if (mult_start) state_d = MULT_FINISH;
      // Leave only once the stage takes the result
      MULT_FINISH: if (ex_ready_i) state_d = MULT_IDLE;
      default:     state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // First cycle of a high product stalls the stage
  assign multicycle_o = mult_start;
  assign ready_o      = ~mult_start;
  assign result_o     = (state_q == MULT_FINISH) ? prod_full[63:32] : mul_lo;

endmodule

// File: verilog/ex_wb_ports.sv
`timescale 1ns/100ps

module ex_wb_ports
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Result sources
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  data_t     alu_result_i,
  input  data_t     mult_result_i,
  input  data_t     csr_rdata_i,

  // Write-port requests from ID
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  // LSU and pipeline control
  input  logic      lsu_err_i,
  input  data_t     lsu_rdata_i,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,

  // Forwarding port
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output data_t     regfile_alu_wdata_fw_o,

  // Load/store port
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output data_t     regfile_wdata_wb_o
);

  logic      lsu_we_masked;
  logic      regfile_we_lsu_q;
  reg_addr_t regfile_waddr_lsu_q;

  //////////////////////////////////////////////////
  // Forwarding port mux
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Later assignments win, so CSR data has top priority
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i)     regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i)    regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  //////////////////////////////////////////////////
  // EX/WB register, load/store port
  //////////////////////////////////////////////////

  // A bus error cancels the register write
  assign lsu_we_masked = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu_q    <= 1'b0;
      regfile_waddr_lsu_q <= '0;
    end else if (ex_valid_i) begin
      regfile_we_lsu_q <= lsu_we_masked;
      if (lsu_we_masked) regfile_waddr_lsu_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // Nothing new arrives, flush the old entry
      regfile_we_lsu_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu_q;
  assign regfile_waddr_wb_o = regfile_waddr_lsu_q;
  // Load data lands one stage later, straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/100ps

module ex_stage
  import ex_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // ALU operands from ID
  input  logic       alu_en_i,
  input  alu_op_e    alu_operator_i,
  input  data_t      alu_operand_a_i,
  input  data_t      alu_operand_b_i,
  input  data_t      alu_operand_c_i,

  // Multiplier operands from ID
  input  logic       mult_en_i,
  input  mul_op_e    mult_operator_i,
  input  data_t      mult_operand_a_i,
  input  data_t      mult_operand_b_i,
  input  logic [1:0] mult_signed_mode_i,
  output logic       mult_multicycle_o,

  // Control from ID
  input  logic       csr_access_i,
  input  data_t      csr_rdata_i,
  input  logic       lsu_en_i,
  input  logic       branch_in_ex_i,
  input  logic       regfile_alu_we_i,
  input  reg_addr_t  regfile_alu_waddr_i,
  input  logic       regfile_we_i,
  input  reg_addr_t  regfile_waddr_i,

  // LSU and WB
  input  data_t      lsu_rdata_i,
  input  logic       lsu_ready_ex_i,
  input  logic       lsu_err_i,
  input  logic       wb_ready_i,

  // Write ports
  output logic       regfile_alu_we_fw_o,
  output reg_addr_t  regfile_alu_waddr_fw_o,
  output data_t      regfile_alu_wdata_fw_o,
  output logic       regfile_we_wb_o,
  output reg_addr_t  regfile_waddr_wb_o,
  output data_t      regfile_wdata_wb_o,

  // Branch outputs to IF
  output data_t      jump_target_o,
  output logic       branch_decision_o,

  // Stall control
  output logic       ex_ready_o,
  output logic       ex_valid_o
);

  data_t alu_result;
  logic  alu_cmp_result;
  data_t mult_result;
  logic  mult_ready;

  //////////////////////////////////////////////////
  // Ready and valid
  //////////////////////////////////////////////////

  // Branches finish here, so they never wait on WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  // Valid does not look at ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                      (mult_ready & lsu_ready_ex_i & wb_ready_i);

  // Branch decision straight from the comparator
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////
  // Datapath units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (mult_en_i),
    .operator_i    (mult_operator_i),
    .op_a_i        (mult_operand_a_i),
    .op_b_i        (mult_operand_b_i),
    .signed_mode_i (mult_signed_mode_i),
    .ex_ready_i    (ex_ready_o),
    .result_o      (mult_result),
    .multicycle_o  (mult_multicycle_o),
    .ready_o       (mult_ready)
  );

  // Forwarding mux and EX/WB register
  ex_wb_ports u_wb_ports (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

endmodule

// File: verification/ex_stage_assert.sv
`timescale 1ns/100ps

module ex_stage_assert (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_o,
  input logic ex_ready_o,
  input logic lsu_ready_ex_i,
  input logic wb_ready_i,
  input logic regfile_we_wb_o,
  input logic mult_multicycle_o
);

  //////////////////////////////////////////////////
  // Stage properties
  //////////////////////////////////////////////////

  // Valid only with both LSU and WB ready
  a_valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> (lsu_ready_ex_i && wb_ready_i))
    else $error("ex_valid_o high while LSU or WB is not ready");

  // No write-back request straight out of reset
  a_we_low_after_reset: assert property (@(posedge clk)
    !rst_n |=> !regfile_we_wb_o)
    else $error("regfile_we_wb_o high right after reset");

  // A stalled high product does not restart
  a_multicycle_once: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_o && !ex_ready_o) |=> !mult_multicycle_o)
    else $error("mult_multicycle_o high twice without the stage taking the result");

endmodule

bind ex_stage ex_stage_assert u_ex_stage_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .ex_valid_o        (ex_valid_o),
  .ex_ready_o        (ex_ready_o),
  .lsu_ready_ex_i    (lsu_ready_ex_i),
  .wb_ready_i        (wb_ready_i),
  .regfile_we_wb_o   (regfile_we_wb_o),
  .mult_multicycle_o (mult_multicycle_o)
);

// File: verification/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int unsigned num_ops    = 2000;
  localparam int unsigned hold_limit = 32;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       alu_en_i, mult_en_i, csr_access_i, lsu_en_i, branch_in_ex_i;
  alu_op_e    alu_operator_i;
  mul_op_e    mult_operator_i;
  data_t      alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  data_t      mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i;
  logic [1:0] mult_signed_mode_i;
  logic       regfile_alu_we_i, regfile_we_i, lsu_ready_ex_i, lsu_err_i, wb_ready_i;
  reg_addr_t  regfile_alu_waddr_i, regfile_waddr_i;
  logic       mult_multicycle_o, regfile_alu_we_fw_o, regfile_we_wb_o;
  reg_addr_t  regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  data_t      regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;
  logic       branch_decision_o, ex_ready_o, ex_valid_o;

  // Reference model state
  logic        mult_busy;
  logic        wb_we_m;
  reg_addr_t   wb_waddr_m;
  logic [31:0] rng_state = 32'hc0e12d78;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  logic        timed_out = 1'b0;

  // 40 ns clock
  always #20 clk = ~clk;

  ex_stage u_ex_stage (.*);

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Compare flag for SLT/SLTU and the branch operators
  function automatic logic cmp_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[shamt_w-1:0];
      ALU_SRL: return a >> b[shamt_w-1:0];
      ALU_SRA: return data_t'($signed(a) >>> b[shamt_w-1:0]);
      default: return {{(data_w-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // Upper word of the 64-bit product, mode bit 0 for A and bit 1 for B
  function automatic data_t mul_high(input data_t a, input data_t b, input logic [1:0] mode);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = {{32{mode[0] & a[31]}}, a};
    b_ext = {{32{mode[1] & b[31]}}, b};
    prod  = a_ext * b_ext;
    return prod[63:32];
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One new instruction from ID, exactly one unit enabled
  task automatic draw_op();
    logic [31:0] r;
    r = next_random();
    alu_en_i            = (r[1:0] == 2'd0);
    mult_en_i           = (r[1:0] == 2'd1);
    csr_access_i        = (r[1:0] == 2'd2);
    lsu_en_i            = (r[1:0] == 2'd3);
    alu_operator_i      = alu_op_e'(r[5:2]);
    mult_operator_i     = mul_op_e'(r[7:6]);
    regfile_alu_we_i    = r[10];
    regfile_we_i        = r[11];
    regfile_alu_waddr_i = r[17:12];
    regfile_waddr_i     = r[23:18];
    branch_in_ex_i      = alu_en_i && (alu_operator_i >= ALU_EQ);
    // Signedness follows the RISC-V meaning of each operator
    case (mult_operator_i)
      MUL_MULH:   mult_signed_mode_i = 2'b11;
      MUL_MULHSU: mult_signed_mode_i = 2'b01;
      MUL_MULHU:  mult_signed_mode_i = 2'b00;
      default:    mult_signed_mode_i = r[9:8];
    endcase
    alu_operand_a_i  = next_random();
    alu_operand_b_i  = next_random();
    alu_operand_c_i  = next_random();
    mult_operand_a_i = next_random();
    mult_operand_b_i = next_random();
    csr_rdata_i      = next_random();
    // Equal operands now and then so EQ/NE both fire
    if (r[26:24] == 3'd0) alu_operand_b_i = alu_operand_a_i;
  endtask

  // LSU and WB side, free to change every cycle
  task automatic drive_bus_side();
    logic [31:0] r;
    r = next_random();
    lsu_ready_ex_i = (r[2:0] != 3'd0);
    wb_ready_i     = (r[5:3] != 3'd0);
    lsu_err_i      = (r[7:6] == 2'd0);
    lsu_rdata_i    = next_random();
  endtask

  //////////////////////////////////////////////////
  // Checks and model update
  //////////////////////////////////////////////////

  task automatic check_outputs();
    logic  start_m;
    logic  mready_m;
    logic  exp_ready;
    logic  exp_valid;
    data_t mult_m;
    data_t fw_m;
    start_m   = mult_en_i && (mult_operator_i != MUL_MUL) && !mult_busy;
    mready_m  = !start_m;
    exp_ready = (mready_m && lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i;
    exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) &&
                mready_m && lsu_ready_ex_i && wb_ready_i;
    mult_m    = mult_busy ? mul_high(mult_operand_a_i, mult_operand_b_i, mult_signed_mode_i)
                          : data_t'(mult_operand_a_i * mult_operand_b_i);
    // CSR wins, then multiplier, then ALU
    if (csr_access_i)   fw_m = csr_rdata_i;
    else if (mult_en_i) fw_m = mult_m;
    else if (alu_en_i)  fw_m = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    else                fw_m = '0;
    check_bit(ex_ready_o, exp_ready, "ex_ready_o");
    check_bit(ex_valid_o, exp_valid, "ex_valid_o");
    check_bit(mult_multicycle_o, start_m, "mult_multicycle_o");
    check_bit(branch_decision_o, cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
              "branch_decision_o");
    check_word(jump_target_o, alu_operand_c_i, "jump_target_o");
    check_bit(regfile_alu_we_fw_o, regfile_alu_we_i, "regfile_alu_we_fw_o");
    check_addr(regfile_alu_waddr_fw_o, regfile_alu_waddr_i, "regfile_alu_waddr_fw_o");
    check_word(regfile_wdata_wb_o, lsu_rdata_i, "regfile_wdata_wb_o");
    // Data in the stall cycle of a high product is not defined
    if (!start_m) check_word(regfile_alu_wdata_fw_o, fw_m, "regfile_alu_wdata_fw_o");
    // State after the coming rising edge
    if (start_m) mult_busy = 1'b1;
    else if (mult_busy && exp_ready) mult_busy = 1'b0;
    if (exp_valid) begin
      wb_we_m = regfile_we_i && !lsu_err_i;
      if (wb_we_m) wb_waddr_m = regfile_waddr_i;
    end else if (wb_ready_i) begin
      wb_we_m = 1'b0;
    end
  endtask

  task automatic check_wb_port();
    check_bit(regfile_we_wb_o, wb_we_m, "regfile_we_wb_o");
    check_addr(regfile_waddr_wb_o, wb_waddr_m, "regfile_waddr_wb_o");
  endtask

  // Hold the instruction until the stage takes it, bounded
  task automatic run_op();
    int unsigned hold_cycles;
    logic        accepted;
    hold_cycles = 0;
    accepted    = 1'b0;
    while (!accepted && !timed_out) begin
      drive_bus_side();
      #10;
      check_outputs();
      accepted = ex_ready_o;
      @(negedge clk);
      check_wb_port();
      if (!accepted) begin
        hold_cycles++;
        if (hold_cycles >= hold_limit) begin
          $display("timeout: ex_ready_o stayed low for %0d cycles", hold_cycles);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i, branch_in_ex_i} = '0;
    {regfile_alu_we_i, regfile_we_i, lsu_err_i} = '0;
    {lsu_ready_ex_i, wb_ready_i} = 2'b11;
    alu_operator_i      = ALU_ADD;
    mult_operator_i     = MUL_MUL;
    mult_signed_mode_i  = 2'b00;
    {alu_operand_a_i, alu_operand_b_i, alu_operand_c_i} = '0;
    {mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i} = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    mult_busy  = 1'b0;
    wb_we_m    = 1'b0;
    wb_waddr_m = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Reset values
    check_wb_port();
    for (int unsigned i = 0; i < num_ops && !timed_out; i++) begin
      draw_op();
      run_op();
    end
    $display("checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/ex_pkg.sv
alu/ex_alu.sv
mult/ex_mult.sv
verilog/ex_wb_ports.sv
verilog/ex_stage.sv
verification/ex_stage_assert.sv
verification/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

dependencies: {}

sources:
  # Shared package first
  - common/ex_pkg.sv
  # Datapath units
  - alu/ex_alu.sv
  - mult/ex_mult.sv
  # Write ports and top level
  - verilog/ex_wb_ports.sv
  - verilog/ex_stage.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/ex_stage_assert.sv
      - verification/tb_ex_stage.sv

# Top modules
#   RTL        ex_stage
#   testbench  tb_ex_stage
